//--- noc_block_radio_core.sv
////////////////////////////////////////////////////////////
// Radio block core
// Settings registers, receive framer and transmit deframer
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module noc_block_radio_core (
   input  logic                                      i_ce_clk,
   input  logic                                      i_rst_n,
   input  radio_regs_pkg::set_bus_t                  i_set,
   input  logic [radio_stream_pkg::SAMPLE_WIDTH-1:0] i_adc_sample,
   input  logic                                      i_adc_stb,
   output radio_stream_pkg::sample_beat_t            o_rx_beat,
   output logic                                      o_rx_tvalid,
   input  logic                                      i_rx_tready,
   input  logic                                      i_dac_stb,
   input  radio_stream_pkg::sample_beat_t            i_tx_beat,
   input  logic                                      i_tx_tvalid,
   output logic                                      o_tx_tready,
   output logic [radio_stream_pkg::SAMPLE_WIDTH-1:0] o_tx_sample,
   output logic [radio_regs_pkg::RB_WIDTH-1:0]       o_rb_data
);
   import radio_regs_pkg::*;
   import radio_stream_pkg::*;

   radio_ctrl_t          ctrl;
   logic [CNT_WIDTH-1:0] overflow_cnt;
   logic [CNT_WIDTH-1:0] underrun_cnt;
   logic [CNT_WIDTH-1:0] rx_count;

   radio_settings_regs u_settings (
      .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
      .i_set(i_set),
      .i_overflow_cnt(overflow_cnt), .i_underrun_cnt(underrun_cnt),
      .i_rx_count(rx_count),
      .o_ctrl(ctrl), .o_rb_data(o_rb_data));

   // ADC side
   rx_framer u_rx_framer (
      .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
      .i_rx_en(ctrl.rx_en), .i_pkt_len(ctrl.pkt_len),
      .i_adc_sample(i_adc_sample), .i_adc_stb(i_adc_stb),
      .o_rx_beat(o_rx_beat), .o_rx_tvalid(o_rx_tvalid), .i_rx_tready(i_rx_tready),
      .o_overflow_cnt(overflow_cnt), .o_rx_count(rx_count));

   // DAC side
   tx_deframer u_tx_deframer (
      .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
      .i_tx_en(ctrl.tx_en), .i_idle_sample(ctrl.idle),
      .i_dac_stb(i_dac_stb),
      .i_tx_beat(i_tx_beat), .i_tx_tvalid(i_tx_tvalid), .o_tx_tready(o_tx_tready),
      .o_tx_sample(o_tx_sample),
      .o_underrun_cnt(underrun_cnt));

endmodule

//--- radio_regs_pkg.sv
////////////////////////////////////////////////////////////
// Radio register map
// Settings bus layout, register addresses and readback selects
////////////////////////////////////////////////////////////

package radio_regs_pkg;

   // Bus and field widths
   localparam int SET_ADDR_WIDTH = 8;
   localparam int SET_DATA_WIDTH = 32;
   localparam int PKT_LEN_WIDTH  = 12;
   localparam int RB_WIDTH       = 64;

   // Receive packet length limits, in samples
   localparam int MIN_PKT_LEN = 1;
   localparam int MAX_PKT_LEN = 2048;

   // User registers sit above the wrapper block at 128
   localparam logic [SET_ADDR_WIDTH-1:0] SR_RX_PKT_LEN = 8'd129;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_RX_ENABLE  = 8'd130;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_TX_IDLE    = 8'd131;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_TX_ENABLE  = 8'd132;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_RB_SELECT  = 8'd133;

   typedef struct packed {
      logic                      stb;
      logic [SET_ADDR_WIDTH-1:0] addr;
      logic [SET_DATA_WIDTH-1:0] data;
   } set_bus_t;

   typedef enum logic [1:0] {
      RB_STATUS   = 2'd0,
      RB_RX_COUNT = 2'd1,
      RB_PKT_LEN  = 2'd2,
      RB_IDLE     = 2'd3
   } rb_sel_e;

   typedef struct packed {
      logic                      rx_en;
      logic                      tx_en;
      logic [PKT_LEN_WIDTH-1:0]  pkt_len;
      logic [SET_DATA_WIDTH-1:0] idle;
   } radio_ctrl_t;

endpackage

//--- radio_settings_regs.sv
////////////////////////////////////////////////////////////
// Radio settings registers
// Decodes settings bus writes and selects the readback word
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module radio_settings_regs (
   input  logic                                   i_ce_clk,
   input  logic                                   i_rst_n,
   input  radio_regs_pkg::set_bus_t               i_set,
   input  logic [radio_stream_pkg::CNT_WIDTH-1:0] i_overflow_cnt,
   input  logic [radio_stream_pkg::CNT_WIDTH-1:0] i_underrun_cnt,
   input  logic [radio_stream_pkg::CNT_WIDTH-1:0] i_rx_count,
   output radio_regs_pkg::radio_ctrl_t            o_ctrl,
   output logic [radio_regs_pkg::RB_WIDTH-1:0]    o_rb_data
);
   import radio_regs_pkg::*;

   radio_ctrl_t ctrl_q;
   rb_sel_e     rb_sel_q;

   // Zero maps to the shortest packet, oversize to the longest
   function automatic logic [PKT_LEN_WIDTH-1:0] limit_len(
      input logic [SET_DATA_WIDTH-1:0] len);
      logic [PKT_LEN_WIDTH-1:0] res;
      if (len < MIN_PKT_LEN)
         res = PKT_LEN_WIDTH'(MIN_PKT_LEN);
      else if (len > MAX_PKT_LEN)
         res = PKT_LEN_WIDTH'(MAX_PKT_LEN);
      else
         res = len[PKT_LEN_WIDTH-1:0];
      return res;
   endfunction

   ////////////////////////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////////////////////////
   always_ff @(posedge i_ce_clk) begin
      if (!i_rst_n) begin
         ctrl_q.rx_en   <= 1'b0;
         ctrl_q.tx_en   <= 1'b0;
         ctrl_q.pkt_len <= PKT_LEN_WIDTH'(MIN_PKT_LEN);
         ctrl_q.idle    <= '0;
         rb_sel_q       <= RB_STATUS;
      end else if (i_set.stb) begin
         case (i_set.addr)
            SR_RX_PKT_LEN: ctrl_q.pkt_len <= limit_len(i_set.data);
            SR_RX_ENABLE:  ctrl_q.rx_en   <= i_set.data[0];
            SR_TX_IDLE:    ctrl_q.idle    <= i_set.data;
            SR_TX_ENABLE:  ctrl_q.tx_en   <= i_set.data[0];
            SR_RB_SELECT:  rb_sel_q       <= rb_sel_e'(i_set.data[1:0]);
            // Addresses of other blocks
            default: ;
         endcase
      end
   end

   assign o_ctrl = ctrl_q;

   ////////////////////////////////////////////////////////////
   // Readback mux
   ////////////////////////////////////////////////////////////
   always_comb begin
      case (rb_sel_q)
         RB_STATUS:   o_rb_data = {i_overflow_cnt, i_underrun_cnt};
         RB_RX_COUNT: o_rb_data = RB_WIDTH'(i_rx_count);
         RB_PKT_LEN:  o_rb_data = RB_WIDTH'(ctrl_q.pkt_len);
         RB_IDLE:     o_rb_data = RB_WIDTH'(ctrl_q.idle);
         default:     o_rb_data = {i_overflow_cnt, i_underrun_cnt};
      endcase
   end

endmodule

//--- radio_stream_pkg.sv
////////////////////////////////////////////////////////////
// Radio sample streams
// Beat layout, framer and deframer states, counter widths
////////////////////////////////////////////////////////////

package radio_stream_pkg;

   localparam int IQ_WIDTH     = 16;
   localparam int SAMPLE_WIDTH = 2 * IQ_WIDTH;

   // Overflow, underrun and sample counters
   localparam int CNT_WIDTH = 32;

   // I in the upper half, Q in the lower
   typedef struct packed {
      logic [IQ_WIDTH-1:0] i;
      logic [IQ_WIDTH-1:0] q;
   } iq_t;

   typedef struct packed {
      iq_t  sample;
      logic last;
   } sample_beat_t;

   // Receive framer
   typedef enum logic {
      RX_OFF = 1'b0,
      RX_RUN = 1'b1
   } rx_state_e;

   // Transmit deframer
   typedef enum logic {
      TX_IDLE  = 1'b0,
      TX_BURST = 1'b1
   } tx_state_e;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the radio core testbench with Verilator
rm -f sim.log
verilator --binary -f sim.f --top-module tb_noc_block_radio_core -o tb_sim || exit 1
./obj_dir/tb_sim > sim.log 2>&1
grep -q "test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "test passed" sim.log || { echo "FAIL: no result in sim.log"; exit 1; }
echo "PASS"

//--- rx_framer.sv
////////////////////////////////////////////////////////////
// Receive framer
// Packs strobed ADC samples into fixed-length packets
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rx_framer (
   input  logic                                       i_ce_clk,
   input  logic                                       i_rst_n,
   input  logic                                       i_rx_en,
   input  logic [radio_regs_pkg::PKT_LEN_WIDTH-1:0]   i_pkt_len,
   input  logic [radio_stream_pkg::SAMPLE_WIDTH-1:0]  i_adc_sample,
   input  logic                                       i_adc_stb,
   output radio_stream_pkg::sample_beat_t             o_rx_beat,
   output logic                                       o_rx_tvalid,
   input  logic                                       i_rx_tready,
   output logic [radio_stream_pkg::CNT_WIDTH-1:0]     o_overflow_cnt,
   output logic [radio_stream_pkg::CNT_WIDTH-1:0]     o_rx_count
);
   import radio_regs_pkg::*;
   import radio_stream_pkg::*;

   rx_state_e                state_q;
   sample_beat_t             beat_q;
   logic                     valid_q;
   logic [PKT_LEN_WIDTH-1:0] pos_q;
   logic [PKT_LEN_WIDTH-1:0] len_q;
   logic [CNT_WIDTH-1:0]     overflow_q;
   logic [CNT_WIDTH-1:0]     count_q;

   logic                     xfer;
   logic                     can_load;
   logic                     load;
   logic                     drop;
   logic                     at_last;
   logic                     leave_run;
   logic [PKT_LEN_WIDTH-1:0] len_cur;

   // Holding register is free when empty or draining this cycle
   assign xfer     = valid_q & i_rx_tready;
   assign can_load = ~valid_q | i_rx_tready;
   assign load     = i_adc_stb & i_rx_en & can_load;
   assign drop     = i_adc_stb & i_rx_en & ~can_load;

   // Length is taken fresh on the first sample of a packet
   assign len_cur = (pos_q == '0) ? i_pkt_len : len_q;
   assign at_last = (pos_q == len_cur - 1'b1);

   // Wait for the held beat before shutting down
   assign leave_run = (state_q == RX_RUN) & ~i_rx_en & (~valid_q | xfer);

   ////////////////////////////////////////////////////////////
   // Control state
   ////////////////////////////////////////////////////////////
   always_ff @(posedge i_ce_clk) begin
      if (!i_rst_n) begin
         state_q    <= RX_OFF;
         valid_q    <= 1'b0;
         pos_q      <= '0;
         overflow_q <= '0;
         count_q    <= '0;
      end else begin
         case (state_q)
            RX_OFF: if (i_rx_en) state_q <= RX_RUN;
            RX_RUN: if (leave_run) state_q <= RX_OFF;
            default: state_q <= RX_OFF;
         endcase

         if (load)
            valid_q <= 1'b1;
         else if (xfer)
            valid_q <= 1'b0;

         if (load)
            pos_q <= at_last ? '0 : pos_q + 1'b1;
         else if (leave_run)
            pos_q <= '0;

         if (load)
            count_q <= count_q + 1'b1;
         if (drop)
            overflow_q <= overflow_q + 1'b1;
      end
   end

   // Payload
   always_ff @(posedge i_ce_clk) begin
      if (load) begin
         beat_q.sample <= i_adc_sample;
         beat_q.last   <= at_last;
      end
      if (load && pos_q == '0)
         len_q <= i_pkt_len;
   end

   assign o_rx_beat      = beat_q;
   assign o_rx_tvalid    = valid_q;
   assign o_overflow_cnt = overflow_q;
   assign o_rx_count     = count_q;

endmodule

//--- sim.f
radio_regs_pkg.sv
radio_stream_pkg.sv
radio_settings_regs.sv
rx_framer.sv
tx_deframer.sv
noc_block_radio_core.sv
tb_noc_block_radio_core.sv

//--- tb_noc_block_radio_core.sv
////////////////////////////////////////////////////////////
// Radio block core testbench
// Table-driven stimulus checked against a cycle reference model
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_noc_block_radio_core;
   import radio_regs_pkg::*;
   import radio_stream_pkg::*;

   typedef enum logic [1:0] {STEP_WR, STEP_RX, STEP_TX, STEP_RB} step_kind_e;

   // Field use by kind is write (addr, data), receive (count, spacing, ready mode),
   // transmit (beats, spacing, gap) and readback (sel, value)
   typedef struct packed {
      step_kind_e  kind;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
   } step_t;

   logic         i_ce_clk;
   logic         i_rst_n;
   set_bus_t     i_set;
   logic [31:0]  i_adc_sample;
   logic         i_adc_stb;
   sample_beat_t o_rx_beat;
   logic         o_rx_tvalid;
   logic         i_rx_tready;
   logic         i_dac_stb;
   sample_beat_t i_tx_beat;
   logic         i_tx_tvalid;
   logic         o_tx_tready;
   logic [31:0]  o_tx_sample;
   logic [63:0]  o_rb_data;

   // Reference model state
   logic         m_rx_en, m_tx_en, m_run, m_valid, m_burst;
   logic [31:0]  m_idle, m_dac;
   sample_beat_t m_beat;
   int           m_len_reg, m_pos, m_plen;
   int           adc_cnt, tx_cnt, tot_stb, tot_deliv, deliv_pos, exp_underrun;
   int           limit_cycles;
   step_t        steps[$];

   noc_block_radio_core u_noc_block_radio_core (.*);

   always #5 i_ce_clk = ~i_ce_clk;

   task automatic fail_run();
      $display("test failed");
      $fatal(1, "stopping on first error");
   endtask

   task automatic compare_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("MISMATCH time=%0t %s expected=%b actual=%b", $time, name, exp, act);
         fail_run();
      end
   endtask

   task automatic compare_beat(input string name, input sample_beat_t exp, input sample_beat_t act);
      if (act !== exp) begin
         $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
         fail_run();
      end
   endtask

   task automatic compare_sample(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
         fail_run();
      end
   endtask

   task automatic compare_rb(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (act !== exp) begin
         $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
         fail_run();
      end
   endtask

   function automatic step_t make_step(input step_kind_e k, input logic [31:0] a,
                                       input logic [31:0] b, input logic [31:0] c);
      step_t s;
      s.kind = k;
      s.a = a;
      s.b = b;
      s.c = c;
      return s;
   endfunction

   // Idle cycles before each strobe, random for spacing 0
   function automatic int space_cycles(input int sp);
      return (sp == 0) ? int'($urandom_range(3, 0)) : sp - 1;
   endfunction

   ////////////////////////////////////////////////////////////
   // Drive one clock cycle, advance the model and check
   ////////////////////////////////////////////////////////////
   task automatic cycle(input set_bus_t s, input logic stb, input logic rdy,
                        input logic dstb, input logic tv, input logic last);
      sample_beat_t tb_beat;
      logic         xfer;
      logic         load;
      logic         take;
      int           len_cur;
      tb_beat.sample = 32'h2000_0000 | 32'(tx_cnt);
      tb_beat.last   = last;
      i_set          = s;
      i_adc_stb      = stb;
      i_adc_sample   = 32'h1000_0000 | 32'(adc_cnt);
      i_rx_tready    = rdy;
      i_dac_stb      = dstb;
      i_tx_tvalid    = tv;
      i_tx_beat      = tb_beat;
      #1 compare_flag("o_tx_tready", dstb & m_tx_en, o_tx_tready);
      // Receive side with one held beat
      xfer    = m_valid & rdy;
      load    = stb & m_rx_en & (~m_valid | rdy);
      len_cur = (m_pos == 0) ? m_len_reg : m_plen;
      if (xfer) begin
         compare_flag("o_rx_beat.last", deliv_pos == m_len_reg - 1, o_rx_beat.last);
         deliv_pos = o_rx_beat.last ? 0 : deliv_pos + 1;
         tot_deliv++;
      end
      if (stb && m_rx_en)
         tot_stb++;
      if (load) begin
         m_beat.sample = i_adc_sample;
         m_beat.last   = (m_pos == len_cur - 1);
         if (m_pos == 0)
            m_plen = m_len_reg;
         m_pos = m_beat.last ? 0 : m_pos + 1;
      end
      if (m_run && !m_rx_en && (!m_valid || xfer)) begin
         m_run = 1'b0;
         m_pos = 0;
      end else if (m_rx_en)
         m_run = 1'b1;
      m_valid = load | (m_valid & ~xfer);
      if (stb)
         adc_cnt++;
      // Transmit side
      take = dstb & m_tx_en & tv;
      // Empty strobe inside a burst
      if (dstb && m_tx_en && !tv && m_burst)
         exp_underrun++;
      if (!m_tx_en) begin
         m_dac   = m_idle;
         m_burst = 1'b0;
      end else if (dstb) begin
         m_dac = take ? tb_beat.sample : m_idle;
         if (take)
            m_burst = ~last;
      end
      if (take)
         tx_cnt++;
      if (s.stb) begin
         case (s.addr)
            SR_RX_PKT_LEN: m_len_reg = (s.data == 0) ? 1 : (s.data > 2048) ? 2048 : int'(s.data);
            SR_RX_ENABLE:  m_rx_en = s.data[0];
            SR_TX_IDLE:    m_idle = s.data;
            SR_TX_ENABLE:  m_tx_en = s.data[0];
            default: ;
         endcase
      end
      @(negedge i_ce_clk);
      compare_flag("o_rx_tvalid", m_valid, o_rx_tvalid);
      if (m_valid)
         compare_beat("o_rx_beat", m_beat, o_rx_beat);
      compare_sample("o_tx_sample", m_dac, o_tx_sample);
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      set_bus_t s;
      s.stb  = 1'b1;
      s.addr = addr;
      s.data = data;
      cycle(s, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
   endtask

   // Strobe until the open packet closes and the held beat drains
   task automatic finish_packet();
      int n;
      n = 0;
      while (m_valid || deliv_pos != 0) begin
         if (n > 2 * m_len_reg + 8) begin
            $display("ERROR: receive packet did not complete by time %0t", $time);
            fail_run();
         end
         cycle('0, m_pos != 0, 1'b1, 1'b0, 1'b0, 1'b0);
         n++;
      end
   endtask

   task automatic run_rx(input int count, input int sp, input logic always_rdy);
      for (int i = 0; i < count; i++) begin
         repeat (space_cycles(sp))
            cycle('0, 1'b0, always_rdy || $urandom_range(1, 0) != 0, 1'b0, 1'b0, 1'b0);
         cycle('0, 1'b1, always_rdy || $urandom_range(1, 0) != 0, 1'b0, 1'b0, 1'b0);
      end
      finish_packet();
   endtask

   // Two empty strobes, half the beats, a gap, the rest, two empty strobes
   task automatic run_tx(input int n, input int sp, input int gap);
      int   start;
      logic tv;
      logic last;
      start = tx_cnt;
      for (int k = 0; k < n + gap + 4; k++) begin
         if (k < 2 || k >= n + gap + 2)
            tv = 1'b0;
         else
            tv = !(k >= 2 + n / 2 && k < 2 + n / 2 + gap);
         last = (tx_cnt - start == n - 1);
         repeat (space_cycles(sp))
            cycle('0, 1'b0, 1'b1, 1'b0, tv, last);
         cycle('0, 1'b0, 1'b1, 1'b1, tv, last);
      end
   endtask

   task automatic check_rb(input logic [31:0] sel, input logic [31:0] value);
      logic [63:0] exp;
      write_reg(SR_RB_SELECT, sel);
      if (sel[1:0] == RB_STATUS)
         exp = {32'(tot_stb - tot_deliv), 32'(exp_underrun)};
      else if (sel[1:0] == RB_RX_COUNT)
         exp = 64'(tot_deliv);
      else
         exp = 64'(value);
      compare_rb("o_rb_data", exp, o_rb_data);
   endtask

   ////////////////////////////////////////////////////////////
   // Watchdog
   ////////////////////////////////////////////////////////////
   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge i_ce_clk);
      $display("ERROR: watchdog expired after %0d cycles", limit_cycles);
      fail_run();
   end

   initial begin
      int total;
      void'($urandom(87));
      i_ce_clk = 1'b0;
      i_rst_n = 1'b0;
      i_set = '0;
      i_adc_sample = '0;
      i_adc_stb = 1'b0;
      i_rx_tready = 1'b0;
      i_dac_stb = 1'b0;
      i_tx_beat = '0;
      i_tx_tvalid = 1'b0;
      {m_rx_en, m_tx_en, m_run, m_valid, m_burst} = '0;
      m_idle = '0;
      m_dac = '0;
      m_beat = '0;
      m_len_reg = 1;
      {m_pos, m_plen, adc_cnt, tx_cnt, tot_stb, tot_deliv, deliv_pos, exp_underrun} = '0;

      steps.push_back(make_step(STEP_WR, 32'(SR_RX_PKT_LEN), 32'd5, 32'd0));
      steps.push_back(make_step(STEP_RB, 32'(RB_PKT_LEN), 32'd5, 32'd0));
      steps.push_back(make_step(STEP_WR, 32'(SR_RX_PKT_LEN), 32'd0, 32'd0));
      steps.push_back(make_step(STEP_RB, 32'(RB_PKT_LEN), 32'd1, 32'd0));
      steps.push_back(make_step(STEP_WR, 32'(SR_TX_IDLE), 32'h1234_5678, 32'd0));
      steps.push_back(make_step(STEP_RB, 32'(RB_IDLE), 32'h1234_5678, 32'd0));
      steps.push_back(make_step(STEP_TX, 32'd4, 32'd2, 32'd0));
      steps.push_back(make_step(STEP_WR, 32'(SR_RX_PKT_LEN), 32'd8, 32'd0));
      steps.push_back(make_step(STEP_WR, 32'(SR_RX_ENABLE), 32'd1, 32'd0));
      steps.push_back(make_step(STEP_RX, 32'd32, 32'd1, 32'd1));
      steps.push_back(make_step(STEP_RB, 32'(RB_RX_COUNT), 32'd0, 32'd0));
      steps.push_back(make_step(STEP_RX, 32'd40, 32'd0, 32'd0));
      steps.push_back(make_step(STEP_RB, 32'(RB_STATUS), 32'd0, 32'd0));
      steps.push_back(make_step(STEP_WR, 32'(SR_TX_ENABLE), 32'd1, 32'd0));
      steps.push_back(make_step(STEP_TX, 32'd6, 32'd3, 32'd3));
      steps.push_back(make_step(STEP_TX, 32'd5, 32'd0, 32'd2));
      steps.push_back(make_step(STEP_RB, 32'(RB_STATUS), 32'd0, 32'd0));
      steps.push_back(make_step(STEP_WR, 32'(SR_RX_ENABLE), 32'd0, 32'd0));
      steps.push_back(make_step(STEP_RX, 32'd4, 32'd1, 32'd1));

      total = 2;
      foreach (steps[i])
         total += (steps[i].kind == STEP_RX || steps[i].kind == STEP_TX) ?
                  int'(steps[i].a + steps[i].c) + 5 : 2;
      limit_cycles = total * 20;

      repeat (10) @(posedge i_ce_clk);
      @(negedge i_ce_clk);
      i_rst_n = 1'b1;
      compare_flag("o_rx_tvalid", 1'b0, o_rx_tvalid);
      compare_sample("o_tx_sample", 32'd0, o_tx_sample);
      compare_rb("o_rb_data", 64'd0, o_rb_data);

      foreach (steps[i]) begin
         case (steps[i].kind)
            STEP_WR: write_reg(steps[i].a[7:0], steps[i].b);
            STEP_RX: run_rx(int'(steps[i].a), int'(steps[i].b), steps[i].c[0]);
            STEP_TX: run_tx(int'(steps[i].a), int'(steps[i].b), int'(steps[i].c));
            default: check_rb(steps[i].a, steps[i].b);
         endcase
      end
      repeat (3) cycle('0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
      $display("test passed");
      $finish;
   end

endmodule

//--- tx_deframer.sv
////////////////////////////////////////////////////////////
// Transmit deframer
// Feeds the DAC one stream beat per strobe, idle otherwise
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tx_deframer (
   input  logic                                      i_ce_clk,
   input  logic                                      i_rst_n,
   input  logic                                      i_tx_en,
   input  logic [radio_stream_pkg::SAMPLE_WIDTH-1:0] i_idle_sample,
   input  logic                                      i_dac_stb,
   input  radio_stream_pkg::sample_beat_t            i_tx_beat,
   input  logic                                      i_tx_tvalid,
   output logic                                      o_tx_tready,
   output logic [radio_stream_pkg::SAMPLE_WIDTH-1:0] o_tx_sample,
   output logic [radio_stream_pkg::CNT_WIDTH-1:0]    o_underrun_cnt
);
   import radio_stream_pkg::*;

   tx_state_e               state_q;
   logic [SAMPLE_WIDTH-1:0] sample_q;
   logic [CNT_WIDTH-1:0]    underrun_q;

   logic                    take;
   logic                    starved;

   // One pop per enabled DAC strobe
   assign o_tx_tready = i_dac_stb & i_tx_en;
   assign take        = o_tx_tready & i_tx_tvalid;
   assign starved     = o_tx_tready & ~i_tx_tvalid;

   ////////////////////////////////////////////////////////////
   // DAC output register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge i_ce_clk) begin
      if (!i_rst_n)
         sample_q <= '0;
      else if (!i_tx_en)
         sample_q <= i_idle_sample;
      else if (i_dac_stb)
         sample_q <= take ? i_tx_beat.sample : i_idle_sample;
   end

   ////////////////////////////////////////////////////////////
   // Burst tracking
   ////////////////////////////////////////////////////////////
   always_ff @(posedge i_ce_clk) begin
      if (!i_rst_n) begin
         state_q    <= TX_IDLE;
         underrun_q <= '0;
      end else if (!i_tx_en) begin
         state_q <= TX_IDLE;
      end else begin
         case (state_q)
            TX_IDLE: begin
               if (take && !i_tx_beat.last)
                  state_q <= TX_BURST;
            end
            TX_BURST: begin
               // Gap inside a burst
               if (starved)
                  underrun_q <= underrun_q + 1'b1;
               if (take && i_tx_beat.last)
                  state_q <= TX_IDLE;
            end
            default: state_q <= TX_IDLE;
         endcase
      end
   end

   assign o_tx_sample    = sample_q;
   assign o_underrun_cnt = underrun_q;

endmodule
